// ==== hdl/bitmanip_cfg_pkg.sv ====
/* data-path widths and word types of the bit-manipulation co-processor
   XLEN is fixed at 32, because the byte and half-word logic is written for RV32 only */
package bitmanip_cfg_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int XLEN    = 32; // data path
  localparam int SHAMT_W = 5;  // bit index into one word
  localparam int CNT_W   = 6;  // clmul iteration count, must hold XLEN

  // ------------------------------
  // vector types
  // ------------------------------
  typedef logic [XLEN-1:0]    xlen_t;    // operand / result word
  typedef logic [2*XLEN-1:0]  dprod_t;   // full carry-less product
  typedef logic [SHAMT_W-1:0] shamt_t;   // bit position
  typedef logic [11:0]        funct12_t; // instr[31:20]
  typedef logic [2:0]         funct3_t;  // instr[14:12]

  // mirror a word, msb <-> lsb
  // clmulr runs the plain multiplier on mirrored operands and mirrors the result
  function automatic xlen_t bit_rev(input xlen_t v);
    xlen_t r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = v[XLEN-1-i];
    end
    return r;
  endfunction

endpackage

// ==== hdl/bitmanip_op_pkg.sv ====
/* one-hot operation vector shared by decode, issue, execute and writeback
   OP_MAX is a qualifier raised together with OP_MINMAX and is not an operation on its own */
package bitmanip_op_pkg;

  // ------------------------------
  // Zbb
  // ------------------------------
  localparam int OP_ANDN   = 0;
  localparam int OP_ORN    = 1;
  localparam int OP_XNOR   = 2;
  localparam int OP_MINMAX = 3;  // min, minu, max, maxu
  localparam int OP_MAX    = 4;  // qualifier, set for max/maxu
  localparam int OP_SEXTB  = 5;
  localparam int OP_SEXTH  = 6;
  localparam int OP_ZEXTH  = 7;
  localparam int OP_ORCB   = 8;
  localparam int OP_REV8   = 9;

  // ------------------------------
  // Zba / Zbs
  // ------------------------------
  localparam int OP_SHADD  = 10; // sh1add, sh2add, sh3add
  localparam int OP_BCLR   = 11;
  localparam int OP_BEXT   = 12;
  localparam int OP_BINV   = 13;
  localparam int OP_BSET   = 14;

  // ------------------------------
  // Zbc, multi-cycle
  // ------------------------------
  localparam int OP_CLMUL  = 15;
  localparam int OP_CLMULH = 16;
  localparam int OP_CLMULR = 17;

  localparam int OP_W = OP_CLMULR + 1; // vector width

  typedef logic [OP_W-1:0] op_vec_t;

  // shift distance of shNadd, taken from funct3[2:1]
  localparam logic [1:0] SHADD_1 = 2'b01; // sh1add, funct3 010
  localparam logic [1:0] SHADD_2 = 2'b10; // sh2add, funct3 100
  localparam logic [1:0] SHADD_3 = 2'b11; // sh3add, funct3 110

endpackage

// ==== hdl/bitmanip_decode.sv ====
`timescale 1ns/1ps
/* minimal decode, legality is checked by the CPU before start
   only funct12[10:9], [7], [5], [2:0] and funct3 are looked at */
module bitmanip_decode (
  input  bitmanip_cfg_pkg::funct12_t funct12_i, // instr[31:20]
  input  bitmanip_cfg_pkg::funct3_t  funct3_i,  // instr[14:12]
  output bitmanip_op_pkg::op_vec_t   op_o       // one-hot plus max qualifier
);
  import bitmanip_op_pkg::*;

  logic [1:0] grp;     // funct12[10:9], instruction group
  logic       f12_7;   // funct12[7]
  logic       f12_5;   // funct12[5], min/max/clmul vs zext.h
  logic [2:0] sub;     // funct12[2:0], rs2 field of the unary ops
  logic       sext;    // sext.b / sext.h group
  op_vec_t    op_core; // op_o with the qualifier masked

  assign grp   = funct12_i[10:9];
  assign f12_7 = funct12_i[7];
  assign f12_5 = funct12_i[5];
  assign sub   = funct12_i[2:0];
  assign sext  = (grp == 2'b11) && !f12_7 && !funct3_i[2];

  // ------------------------------
  // Zbb
  // ------------------------------
  // logic with negate, funct7 0100000
  assign op_o[OP_ANDN]   = (grp == 2'b10) && !f12_7 && (funct3_i[1:0] == 2'b11);
  assign op_o[OP_ORN]    = (grp == 2'b10) && !f12_7 && (funct3_i[1:0] == 2'b10);
  assign op_o[OP_XNOR]   = (grp == 2'b10) && !f12_7 && (funct3_i[1:0] == 2'b00);

  // funct7 0000101 shares min/max and clmul, funct3[2] splits them
  assign op_o[OP_MINMAX] = (grp == 2'b00) && f12_5 && funct3_i[2];
  assign op_o[OP_MAX]    = (grp == 2'b00) && f12_5 && (funct3_i[2:1] == 2'b11);
  assign op_o[OP_ZEXTH]  = (grp == 2'b00) && !f12_5;

  assign op_o[OP_SEXTB]  = sext && (sub == 3'b100);
  assign op_o[OP_SEXTH]  = sext && (sub == 3'b101);
  assign op_o[OP_ORCB]   = (grp == 2'b01) && f12_7 && (funct3_i == 3'b101);
  assign op_o[OP_REV8]   = (grp == 2'b11) && f12_7 && (funct3_i == 3'b101);

  // ------------------------------
  // Zba / Zbs
  // ------------------------------
  assign op_o[OP_SHADD]  = (grp == 2'b01) && !f12_7 && (|funct3_i[2:1]); // distance in issue
  assign op_o[OP_BCLR]   = (grp == 2'b10) && f12_7 && !funct3_i[2];
  assign op_o[OP_BEXT]   = (grp == 2'b10) && f12_7 && funct3_i[2];
  assign op_o[OP_BINV]   = (grp == 2'b11) && f12_7 && !funct3_i[2];
  assign op_o[OP_BSET]   = (grp == 2'b01) && f12_7 && !funct3_i[2];

  // ------------------------------
  // Zbc
  // ------------------------------
  assign op_o[OP_CLMUL]  = (grp == 2'b00) && f12_5 && (funct3_i == 3'b001);
  assign op_o[OP_CLMULR] = (grp == 2'b00) && f12_5 && (funct3_i == 3'b010);
  assign op_o[OP_CLMULH] = (grp == 2'b00) && f12_5 && (funct3_i == 3'b011);

  // groups above overlap only through funct3, so one wrong compare shows up here
  always_comb begin : onehot_chk
    op_core         = op_o;
    op_core[OP_MAX] = 1'b0;
    if (!$isunknown(op_o)) begin
      assert final ($onehot0(op_core))
        else $error("decode: more than one operation selected, op %b", op_o);
    end
  end

endmodule

// ==== hdl/bitmanip_issue.sv ====
`timescale 1ns/1ps
/* operand capture and sequencing, one instruction in flight
   start_i is only honoured in idle; a trap ends a running clmul without a valid result */
module bitmanip_issue (
  input  logic                      clk_i,
  input  logic                      rstn_i,        // async, active low
  input  logic                      start_i,       // one-cycle strobe
  input  logic                      trap_i,        // level, seen only while clmul runs
  input  bitmanip_op_pkg::op_vec_t  op_i,          // from decode, combinational
  input  bitmanip_cfg_pkg::funct3_t funct3_i,
  input  bitmanip_cfg_pkg::xlen_t   rs1_i,
  input  bitmanip_cfg_pkg::xlen_t   rs2_i,
  input  bitmanip_cfg_pkg::shamt_t  shamt_i,
  input  logic                      less_i,        // comparator, rs1 < rs2
  input  logic                      clmul_busy_i,
  output bitmanip_op_pkg::op_vec_t  op_o,
  output logic [1:0]                shadd_sel_o,   // funct3[2:1]
  output bitmanip_cfg_pkg::xlen_t   rs1_o,
  output bitmanip_cfg_pkg::xlen_t   rs2_o,
  output bitmanip_cfg_pkg::shamt_t  shamt_o,
  output logic                      less_o,
  output logic                      clmul_start_o, // one-cycle pulse
  output logic                      done_o         // one-cycle pulse to writeback
);
  import bitmanip_op_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,      // wait for start
    S_START_MUL, // clmul loads, busy not visible yet
    S_BUSY_MUL   // wait for busy to drop or a trap
  } state_t;

  state_t state_q;
  logic   is_clmul; // incoming op needs the multiplier
  logic   accept;   // start taken this cycle

  assign is_clmul = op_i[OP_CLMUL] | op_i[OP_CLMULH] | op_i[OP_CLMULR];
  assign accept   = start_i && (state_q == S_IDLE);

  // ------------------------------
  // control FSM
  // ------------------------------
  always_ff @(posedge clk_i or negedge rstn_i) begin : ctrl_fsm
    if (!rstn_i) begin
      state_q       <= S_IDLE;
      op_o          <= '0;
      clmul_start_o <= 1'b0;
      done_o        <= 1'b0;
    end else begin
      clmul_start_o <= 1'b0; // pulses by default
      done_o        <= 1'b0;
      unique case (state_q)
        S_IDLE: begin
          if (start_i) begin
            op_o <= op_i;
            if (is_clmul) begin
              clmul_start_o <= 1'b1;
              state_q       <= S_START_MUL;
            end else begin
              done_o <= 1'b1; // single-cycle ops, result next cycle
            end
          end
        end
        S_START_MUL: begin
          state_q <= S_BUSY_MUL;
        end
        S_BUSY_MUL: begin
          if (!clmul_busy_i || trap_i) begin // finished or aborted
            done_o  <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // ------------------------------
  // operand registers
  // ------------------------------
  always_ff @(posedge clk_i) begin : operand_regs
    if (accept) begin
      rs1_o       <= rs1_i;
      rs2_o       <= rs2_i;
      shamt_o     <= shamt_i;
      less_o      <= less_i;
      shadd_sel_o <= funct3_i[2:1]; // shNadd distance
    end
  end

  // the CPU must not issue again before valid_o
  a_start_idle : assert property (@(posedge clk_i) disable iff (!rstn_i)
    start_i |-> (state_q == S_IDLE))
    else $error("issue: start while an instruction is in flight");

endmodule

// ==== hdl/bitmanip_alu.sv ====
`timescale 1ns/1ps
/* single-cycle execute on the registered operands
   res_o is the OR of all gated partial results, zero for clmul ops */
module bitmanip_alu (
  input  bitmanip_op_pkg::op_vec_t op_i,
  input  logic [1:0]               shadd_sel_i, // shNadd distance
  input  bitmanip_cfg_pkg::xlen_t  rs1_i,
  input  bitmanip_cfg_pkg::xlen_t  rs2_i,
  input  bitmanip_cfg_pkg::shamt_t shamt_i,
  input  logic                     less_i,      // signedness already applied by the CPU
  output bitmanip_cfg_pkg::xlen_t  res_o
);
  import bitmanip_cfg_pkg::*;
  import bitmanip_op_pkg::*;

  xlen_t orcb;   // per byte all-ones if any bit set
  xlen_t rev8;   // byte swap
  xlen_t rs1_sh; // rs1 shifted for shNadd
  xlen_t shadd;
  xlen_t mask;   // one-hot of shamt

  // ------------------------------
  // byte-wise helpers
  // ------------------------------
  for (genvar b = 0; b < XLEN/8; b++) begin : g_byte
    assign orcb[8*b +: 8] = {8{|rs1_i[8*b +: 8]}};
    assign rev8[8*b +: 8] = rs1_i[XLEN-8-8*b +: 8]; // byte b <- byte n-1-b
  end

  // address generation
  always_comb begin : shift_add
    unique case (shadd_sel_i)
      SHADD_1: rs1_sh = rs1_i << 1;
      SHADD_2: rs1_sh = rs1_i << 2;
      SHADD_3: rs1_sh = rs1_i << 3;
      default: rs1_sh = '0; // not decoded as shNadd
    endcase
  end

  assign shadd = rs2_i + rs1_sh;
  assign mask  = xlen_t'(1) << shamt_i;

  // ------------------------------
  // gated result OR
  // ------------------------------
  always_comb begin : res_or
    res_o = '0;
    // logic with negate
    if (op_i[OP_ANDN]) res_o |= rs1_i & ~rs2_i;
    if (op_i[OP_ORN])  res_o |= rs1_i | ~rs2_i;
    if (op_i[OP_XNOR]) res_o |= ~(rs1_i ^ rs2_i);
    // min takes rs1 when less, max when not less
    if (op_i[OP_MINMAX]) begin
      res_o |= (less_i ^ op_i[OP_MAX]) ? rs1_i : rs2_i;
    end
    // extensions
    if (op_i[OP_SEXTB]) res_o |= {{(XLEN-8){rs1_i[7]}}, rs1_i[7:0]};
    if (op_i[OP_SEXTH]) res_o |= {{(XLEN-16){rs1_i[15]}}, rs1_i[15:0]};
    if (op_i[OP_ZEXTH]) res_o |= {{(XLEN-16){1'b0}}, rs1_i[15:0]};
    if (op_i[OP_ORCB])  res_o |= orcb;
    if (op_i[OP_REV8])  res_o |= rev8;
    if (op_i[OP_SHADD]) res_o |= shadd;
    // single-bit
    if (op_i[OP_BCLR]) res_o |= rs1_i & ~mask;
    if (op_i[OP_BEXT]) res_o |= xlen_t'(|(rs1_i & mask)); // bit lands in lsb
    if (op_i[OP_BINV]) res_o |= rs1_i ^ mask;
    if (op_i[OP_BSET]) res_o |= rs1_i | mask;
  end

endmodule

// ==== hdl/bitmanip_clmul.sv ====
`timescale 1ns/1ps
/* iterative carry-less multiplier, one rs1 bit per cycle, XLEN cycles per product
   operands must stay stable while busy_o is high; a new start reloads at once */
module bitmanip_clmul (
  input  logic                     clk_i,
  input  logic                     rstn_i,  // async, active low
  input  logic                     start_i, // one-cycle load strobe
  input  logic                     rev_i,   // clmulr, mirror both operands
  input  bitmanip_cfg_pkg::xlen_t  rs1_i,
  input  bitmanip_cfg_pkg::xlen_t  rs2_i,
  output logic                     busy_o,
  output bitmanip_cfg_pkg::dprod_t prod_o   // hi: accumulator, lo: remaining rs1 bits
);
  import bitmanip_cfg_pkg::*;

  logic [CNT_W-1:0] cnt_q;  // iterations left
  xlen_t            addend; // rs2, mirrored for clmulr
  xlen_t            hi_nxt; // upper half after this step

  assign addend = rev_i ? bit_rev(rs2_i) : rs2_i;
  assign hi_nxt = prod_o[2*XLEN-1:XLEN] ^ (prod_o[0] ? addend : '0);
  assign busy_o = |cnt_q;

  // ------------------------------
  // iteration counter
  // ------------------------------
  always_ff @(posedge clk_i or negedge rstn_i) begin : iter_cnt
    if (!rstn_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CNT_W'(XLEN);
    end else if (busy_o) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // shift-right accumulate, the product builds up from the top
  always_ff @(posedge clk_i) begin : prod_reg
    if (start_i) begin
      prod_o <= {xlen_t'(0), (rev_i ? bit_rev(rs1_i) : rs1_i)};
    end else if (busy_o) begin
      prod_o <= {1'b0, hi_nxt, prod_o[XLEN-1:1]}; // msb stays 0 for XLEN x XLEN
    end
  end

  // busy has to cover exactly XLEN steps, issue waits on its falling edge
  a_busy_len : assert property (@(posedge clk_i) disable iff (!rstn_i)
    start_i ##1 (!start_i)[*XLEN] |=> !busy_o && $past(busy_o))
    else $error("clmul: busy did not fall %0d cycles after start", XLEN);

endmodule

// ==== hdl/bitmanip_writeback.sv ====
`timescale 1ns/1ps
/* result select and output register, no back-pressure
   res_o is non-zero only in the cycle valid_o is high */
module bitmanip_writeback (
  input  logic                     clk_i,
  input  logic                     rstn_i,    // async, active low
  input  logic                     done_i,    // one-cycle pulse from issue
  input  bitmanip_op_pkg::op_vec_t op_i,
  input  bitmanip_cfg_pkg::xlen_t  alu_res_i, // zero for clmul ops
  input  bitmanip_cfg_pkg::dprod_t prod_i,
  output bitmanip_cfg_pkg::xlen_t  res_o,
  output logic                     valid_o
);
  import bitmanip_cfg_pkg::*;
  import bitmanip_op_pkg::*;

  xlen_t res_sel; // chosen source

  // ------------------------------
  // source select
  // ------------------------------
  always_comb begin : src_mux
    res_sel = alu_res_i;
    if (op_i[OP_CLMUL]) begin
      res_sel = prod_i[XLEN-1:0];
    end else if (op_i[OP_CLMULH]) begin
      res_sel = prod_i[2*XLEN-1:XLEN];
    end else if (op_i[OP_CLMULR]) begin
      res_sel = bit_rev(prod_i[XLEN-1:0]); // operands were mirrored on load
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin : out_reg
    if (!rstn_i) begin
      res_o   <= '0;
      valid_o <= 1'b0;
    end else begin
      res_o   <= done_i ? res_sel : '0; // zero between results
      valid_o <= done_i;
    end
  end

endmodule

// ==== hdl/bitmanip_top.sv ====
`timescale 1ns/1ps
/* RV32 bit-manipulation co-processor, Zba/Zbb/Zbc/Zbs without shifts and counts
   one instruction at a time; start_i only after valid_o of the previous one */
module bitmanip_top (
  input  logic                      clk_i,
  input  logic                      rstn_i,    // async, active low
  input  logic                      start_i,   // one-cycle strobe
  input  logic                      trap_i,    // aborts a running clmul
  input  bitmanip_cfg_pkg::funct12_t funct12_i,
  input  bitmanip_cfg_pkg::funct3_t  funct3_i,
  input  bitmanip_cfg_pkg::xlen_t    rs1_i,
  input  bitmanip_cfg_pkg::xlen_t    rs2_i,
  input  bitmanip_cfg_pkg::shamt_t   shamt_i,
  input  logic                      less_i,    // comparator, rs1 < rs2
  output bitmanip_cfg_pkg::xlen_t    res_o,
  output logic                      valid_o    // one-cycle pulse
);
  import bitmanip_cfg_pkg::*;
  import bitmanip_op_pkg::*;

  op_vec_t    op_dec;      // decode -> issue
  op_vec_t    op_q;        // registered op
  logic [1:0] shadd_sel;
  xlen_t      rs1_q;
  xlen_t      rs2_q;
  shamt_t     shamt_q;
  logic       less_q;
  logic       clmul_start;
  logic       clmul_busy;
  logic       done;
  xlen_t      alu_res;
  dprod_t     prod;

  // ------------------------------
  // stage chain
  // ------------------------------
  bitmanip_decode u_decode (
    .funct12_i (funct12_i),
    .funct3_i  (funct3_i),
    .op_o      (op_dec)
  );

  bitmanip_issue u_issue (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .start_i       (start_i),
    .trap_i        (trap_i),
    .op_i          (op_dec),
    .funct3_i      (funct3_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .shamt_i       (shamt_i),
    .less_i        (less_i),
    .clmul_busy_i  (clmul_busy),
    .op_o          (op_q),
    .shadd_sel_o   (shadd_sel),
    .rs1_o         (rs1_q),
    .rs2_o         (rs2_q),
    .shamt_o       (shamt_q),
    .less_o        (less_q),
    .clmul_start_o (clmul_start),
    .done_o        (done)
  );

  bitmanip_alu u_alu (
    .op_i        (op_q),
    .shadd_sel_i (shadd_sel),
    .rs1_i       (rs1_q),
    .rs2_i       (rs2_q),
    .shamt_i     (shamt_q),
    .less_i      (less_q),
    .res_o       (alu_res)
  );

  bitmanip_clmul u_clmul (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .start_i (clmul_start),
    .rev_i   (op_q[OP_CLMULR]), // clmulr mirrors operands
    .rs1_i   (rs1_q),
    .rs2_i   (rs2_q),
    .busy_o  (clmul_busy),
    .prod_o  (prod)
  );

  bitmanip_writeback u_writeback (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .done_i    (done),
    .op_i      (op_q),
    .alu_res_i (alu_res),
    .prod_i    (prod),
    .res_o     (res_o),
    .valid_o   (valid_o)
  );

endmodule

// ==== verif/bitmanip_tb.sv ====
`timescale 1ns/1ps
/* trace-driven testbench run from the project root to find verif/bitmanip_trace.txt
   trap lines only check that valid_o follows the abort and leave the value unchecked */
module bitmanip_tb;
  import bitmanip_cfg_pkg::*;

  localparam int MAX_LINES = 64;
  localparam int T_HALF    = 20; // 40 ns clock
  localparam int T_DRV     = 2;  // input skew after posedge

  logic     clk_i;
  logic     rstn_i;
  logic     start_i;
  logic     trap_i;
  funct12_t funct12_i;
  funct3_t  funct3_i;
  xlen_t    rs1_i;
  xlen_t    rs2_i;
  shamt_t   shamt_i;
  logic     less_i;
  xlen_t    res_o;
  logic     valid_o;

  // trace contents per instruction
  logic [8*16-1:0] t_name [MAX_LINES];
  funct12_t        t_f12 [MAX_LINES];
  funct3_t         t_f3 [MAX_LINES];
  xlen_t           t_rs1 [MAX_LINES];
  xlen_t           t_rs2 [MAX_LINES];
  shamt_t          t_shamt [MAX_LINES];
  logic            t_less [MAX_LINES];
  int              t_trap [MAX_LINES]; // edge after start or 0 for none
  xlen_t           t_exp [MAX_LINES];

  int   n_lines;
  int   cycle_cnt   = 0;
  int   cycle_limit = 0; // 0 until the trace is loaded
  int   edges;           // posedges since start was driven
  int   idx;
  logic got;
  logic valid_prev = 1'b0;

  bitmanip_top dut_i (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .start_i   (start_i),
    .trap_i    (trap_i),
    .funct12_i (funct12_i),
    .funct3_i  (funct3_i),
    .rs1_i     (rs1_i),
    .rs2_i     (rs2_i),
    .shamt_i   (shamt_i),
    .less_i    (less_i),
    .res_o     (res_o),
    .valid_o   (valid_o)
  );

  always #(T_HALF) clk_i = ~clk_i;

  task automatic check_val(input logic [8*16-1:0] name, input xlen_t exp_v, input xlen_t act_v);
    if (exp_v !== act_v) begin
      $display("** Error %0s: expected %h, actual %h", name, exp_v, act_v);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input logic [8*16-1:0] name, input logic [8*48-1:0] msg);
    $display("%0s: %0s", name, msg);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
  endtask

  // Zbc ops are funct7 0000101 with funct3 001..011
  function automatic logic is_carryless(input funct12_t f12, input funct3_t f3);
    return (f12[11:5] == 7'b0000101) && !f3[2] && (f3 != 3'b000);
  endfunction

  task automatic load_trace(output int count);
    int               fd;
    int               code;
    logic [8*160-1:0] line;
    count = 0;
    fd = $fopen("verif/bitmanip_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/bitmanip_trace.txt");
    end else begin
      while (!$feof(fd) && count < MAX_LINES) begin
        line = '0;
        code = $fgets(line, fd);
        if (code > 0) begin
          code = $sscanf(line, "%s %h %h %h %h %h %h %d %h", t_name[count], t_f12[count],
                         t_f3[count], t_rs1[count], t_rs2[count], t_shamt[count],
                         t_less[count], t_trap[count], t_exp[count]);
          if (code == 9) count++; // comments and blank lines drop out here
        end
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------
  // watchdog and output monitor
  // ------------------------------
  always @(posedge clk_i) begin : watchdog
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      abort_run("watchdog", "no valid_o before the cycle limit");
    end
  end

  always @(negedge clk_i) begin : out_monitor
    if (rstn_i) begin
      if (!valid_o) check_val("res_idle", '0, res_o); // zero outside the pulse
      check_val("valid_pulse", '0, valid_o & valid_prev);
      valid_prev = valid_o;
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin : run_trace
    clk_i     = 1'b0;
    rstn_i    = 1'b0;
    start_i   = 1'b0;
    trap_i    = 1'b0;
    funct12_i = '0;
    funct3_i  = '0;
    rs1_i     = '0;
    rs2_i     = '0;
    shamt_i   = '0;
    less_i    = 1'b0;
    load_trace(n_lines);
    if (n_lines == 0) begin
      abort_run("trace", "no instructions read from the trace file");
    end else begin
      cycle_limit = n_lines * (XLEN + 10) + 20;
      repeat (8) @(posedge clk_i);
      #(T_DRV) rstn_i = 1'b1;
      for (idx = 0; idx < n_lines; idx++) begin
        @(posedge clk_i);
        #(T_DRV);
        funct12_i = t_f12[idx];
        funct3_i  = t_f3[idx];
        rs1_i     = t_rs1[idx];
        rs2_i     = t_rs2[idx];
        shamt_i   = t_shamt[idx];
        less_i    = t_less[idx];
        trap_i    = 1'b0; // left over from a trap line
        start_i   = 1'b1;
        edges     = 0;
        got       = 1'b0;
        while (!got) begin
          @(posedge clk_i);
          #(T_DRV);
          start_i = 1'b0;
          edges++;
          if (t_trap[idx] != 0 && edges == t_trap[idx]) trap_i = 1'b1;
          @(negedge clk_i);
          got = valid_o;
        end
        if (t_trap[idx] != 0) begin
          if (edges > t_trap[idx] + 2) abort_run(t_name[idx], "valid_o late after trap");
        end else if (is_carryless(t_f12[idx], t_f3[idx])) begin
          if (edges > XLEN + 4) abort_run(t_name[idx], "carry-less result too late");
          check_val(t_name[idx], t_exp[idx], res_o);
        end else begin
          check_val(t_name[idx], 2, edges); // start edge plus one
          check_val(t_name[idx], t_exp[idx], res_o);
        end
      end
      repeat (2) @(posedge clk_i); // monitor still sees the cycle after the last result
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// ==== verif/bitmanip_trace.txt ====
# name funct12 funct3 rs1 rs2 shamt less trap_cycle expected
# all fields hex except trap_cycle, decimal edge count after start, 0 for no trap
andn        400 7 12345678 0ff00ff0 00 0 0  10045008
orn         400 6 12345678 0ff00ff0 00 0 0  f23ff67f
xnor        400 4 12345678 0ff00ff0 00 0 0  e23ba677
min_less    0a0 4 12345678 0ff00ff0 00 1 0  12345678
min_ge      0a0 4 12345678 0ff00ff0 00 0 0  0ff00ff0
max_less    0a0 6 12345678 0ff00ff0 00 1 0  0ff00ff0
maxu_ge     0a0 7 12345678 0ff00ff0 00 0 0  12345678
sext_b      604 1 123456a5 00000000 00 0 0  ffffffa5
sext_h      605 1 12348001 00000000 00 0 0  ffff8001
zext_h      080 4 deadbeef 00000000 00 0 0  0000beef
orc_b       287 5 01008000 00000000 00 0 0  ff00ff00
rev8        698 5 12345678 00000000 00 0 0  78563412
sh1add      200 2 12345678 00001000 00 0 0  2468bcf0
sh2add      200 4 12345678 00001000 00 0 0  48d169e0
sh3add      200 6 12345678 00001000 00 0 0  91a2c3c0
bclr_0      480 1 80020001 00000000 00 0 0  80020000
bclr_31     480 1 80020001 00000000 1f 0 0  00020001
bext_17     480 5 80020001 00000000 11 0 0  00000001
bext_31     480 5 7fffffff 00000000 1f 0 0  00000000
binv_0      680 1 12345678 00000000 00 0 0  12345679
binv_17     680 1 12345678 00000000 11 0 0  12365678
bset_17     280 1 00000000 00000000 11 0 0  00020000
bset_31     280 1 00000001 00000000 1f 0 0  80000001
clmul_a     0a0 1 80000003 00000005 00 0 0  8000000f
clmulh_a    0a0 3 80000003 00000005 00 0 0  00000002
clmulr_a    0a0 2 80000003 00000005 00 0 0  00000005
clmulh_ones 0a0 3 ffffffff ffffffff 00 0 0  55555555
clmulr_ones 0a0 2 ffffffff ffffffff 00 0 0  aaaaaaaa
clmul_trap  0a0 1 ffffffff ffffffff 00 0 10 00000000
andn_after  400 7 12345678 0ff00ff0 00 0 0  10045008

// ==== compile.f ====
hdl/bitmanip_cfg_pkg.sv
hdl/bitmanip_op_pkg.sv
hdl/bitmanip_decode.sv
hdl/bitmanip_issue.sv
hdl/bitmanip_alu.sv
hdl/bitmanip_clmul.sv
hdl/bitmanip_writeback.sv
hdl/bitmanip_top.sv
verif/bitmanip_tb.sv

// ==== Bender.yml ====
package:
  name: bitmanip

sources:
  # packages first, the stages import them
  - hdl/bitmanip_cfg_pkg.sv
  - hdl/bitmanip_op_pkg.sv
  - hdl/bitmanip_decode.sv
  - hdl/bitmanip_issue.sv
  - hdl/bitmanip_alu.sv
  - hdl/bitmanip_clmul.sv
  - hdl/bitmanip_writeback.sv
  - hdl/bitmanip_top.sv
  - target: test
    files:
      - verif/bitmanip_tb.sv
